//--- logic/erx_pkg.sv
package erx_pkg;

   localparam int AW            = 32;                    // Mesh address width
   localparam int DW            = 32;                    // Mesh data width
   localparam int BEAT_W        = 64;                    // Parallel data per beat
   localparam int FRAME_W       = 8;                     // Frame bits per beat

   localparam int MMU_IDX_W     = 4;                     // Table index, top addr bits
   localparam int MMU_ENT_W     = 12;                    // Replaced top addr bits
   localparam int MMU_ENTRIES   = 2 ** MMU_IDX_W;        // Table size

   localparam int FIFO_DEPTH    = 16;                    // Entries per queue
   localparam int FIFO_AW       = $clog2(FIFO_DEPTH);    // Queue pointer width
   localparam int FIFO_CNT_W    = FIFO_AW + 1;           // Occupancy, holds full value
   // One packet in decode plus two transactions in flight still fit above this
   localparam int FIFO_PROGFULL = FIFO_DEPTH - 4;

   localparam logic [MMU_ENT_W-1:0] RR_TAG = 12'h810;    // Read response prefix

   localparam int NUM_CHAN      = 3;                     // Output queues

   typedef enum logic [1:0] {
      DMODE_BYTE   = 2'd0,
      DMODE_HALF   = 2'd1,
      DMODE_WORD   = 2'd2,
      DMODE_DOUBLE = 2'd3
   } dmode_e;

   typedef enum logic [1:0] {
      CHAN_WR = 2'd0,                                    // Host writes
      CHAN_RQ = 2'd1,                                    // Read requests
      CHAN_RR = 2'd2                                     // Read responses
   } chan_e;

   typedef enum logic {
      ST_HEAD = 1'b0,                                    // Expecting head beat
      ST_BODY = 1'b1                                     // Expecting body beat
   } rx_state_e;

   typedef struct packed {
      logic                 write;
      dmode_e               datamode;
      logic [3:0]           ctrlmode;
      logic [AW-1:0]        dstaddr;
      logic [AW-1:0]        srcaddr;
      logic [DW-1:0]        data;
   } emesh_txn_t;                                        // 103 bits

   typedef struct packed {
      logic [FRAME_W-1:0]   frame;
      logic [BEAT_W-1:0]    data;
   } rx_beat_t;                                          // 72 bits

   typedef struct packed {
      logic                 en;
      logic                 we;
      logic [MMU_IDX_W-1:0] addr;
      logic [MMU_ENT_W-1:0] din;
   } mi_req_t;                                           // 18 bits

endpackage

//--- logic/erx_protocol.sv
`timescale 1ns/1ps

module erx_protocol
   import erx_pkg::*;
(
   input  logic       rx_lclk_div4,
   input  logic       arst_n,
   input  rx_beat_t   beat,                              // Parallel beat, no handshake
   input  logic       out_ready,
   output logic       out_valid,
   output emesh_txn_t out_txn
);

   rx_state_e     state;                                 // Head or body expected
   logic          beat_ok;                               // Full frame seen
   logic          head_take;
   logic          body_take;

   logic          hd_write;                              // Head fields held for body
   dmode_e        hd_datamode;
   logic [3:0]    hd_ctrlmode;
   logic [AW-1:0] hd_dstaddr;

   assign beat_ok   = &beat.frame;                       // All frame bits high
   assign head_take = beat_ok && (state == ST_HEAD);
   // Output register free or draining this cycle
   assign body_take = beat_ok && (state == ST_BODY) && (!out_valid || out_ready);

   always_ff @(posedge rx_lclk_div4 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= ST_HEAD;
         out_valid <= 1'b0;
      end
      else
      begin
         if (out_valid && out_ready)
            out_valid <= 1'b0;                           // Taken by the MMU
         if (body_take)
            out_valid <= 1'b1;                           // New txn overrides the clear
         if (!beat_ok)
            state <= ST_HEAD;                            // Frame dropped, resync
         else if (state == ST_HEAD)
            state <= ST_BODY;
         else
            state <= ST_HEAD;                            // Body done, back to head
      end
   end

   // Payload capture
   always_ff @(posedge rx_lclk_div4)
   begin
      if (head_take)
      begin
         hd_write    <= beat.data[63];                   // Write flag
         hd_datamode <= dmode_e'(beat.data[62:61]);
         hd_ctrlmode <= beat.data[60:57];
         hd_dstaddr  <= beat.data[AW-1:0];               // Low word is destination
      end
      if (body_take)
      begin
         out_txn.write    <= hd_write;
         out_txn.datamode <= hd_datamode;
         out_txn.ctrlmode <= hd_ctrlmode;
         out_txn.dstaddr  <= hd_dstaddr;
         out_txn.data     <= beat.data[BEAT_W-1 -: DW];  // High word is data
         out_txn.srcaddr  <= beat.data[AW-1:0];          // Low word is source
      end
   end

endmodule

//--- logic/emmu.sv
`timescale 1ns/1ps

module emmu
   import erx_pkg::*;
(
   input  logic                 rx_lclk_div4,
   input  logic                 arst_n,
   input  logic                 mmu_en,                  // Translation on
   input  mi_req_t              mi,                      // Table config request
   output logic [MMU_ENT_W-1:0] mi_dout,                 // Table readback
   input  logic                 in_valid,
   input  emesh_txn_t           in_txn,
   output logic                 in_ready,
   input  logic                 out_ready,
   output logic                 out_valid,
   output emesh_txn_t           out_txn
);

   logic [MMU_ENT_W-1:0] mmu_tbl [MMU_ENTRIES];          // Lookup table
   logic [MMU_IDX_W-1:0] xl_idx;                         // Entry picked by address
   emesh_txn_t           xl_txn;                         // Translated transaction
   logic                 accept;

   assign mi_dout = mmu_tbl[mi.addr];                    // Combinational readback

   // Table write port
   always_ff @(posedge rx_lclk_div4 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < MMU_ENTRIES; i++)
            mmu_tbl[i] <= '0;                            // Table starts all zero
      end
      else if (mi.en && mi.we)
      begin
         mmu_tbl[mi.addr] <= mi.din;
      end
   end

   assign xl_idx = in_txn.dstaddr[AW-1 -: MMU_IDX_W];    // Top address bits

   always_comb
   begin
      xl_txn = in_txn;
      if (mmu_en)
         xl_txn.dstaddr[AW-1 -: MMU_ENT_W] = mmu_tbl[xl_idx];  // Swap top 12 bits
   end

   // Stage empty or emptying this cycle
   assign in_ready = !out_valid || out_ready;
   assign accept   = in_valid && in_ready;

   always_ff @(posedge rx_lclk_div4 or negedge arst_n)
   begin
      if (!arst_n)
         out_valid <= 1'b0;
      else if (accept)
         out_valid <= 1'b1;
      else if (out_ready)
         out_valid <= 1'b0;                              // Drained, nothing new
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (accept)
         out_txn <= xl_txn;                              // Hold until taken
   end

endmodule

//--- logic/erx_disty.sv
`timescale 1ns/1ps

module erx_disty
   import erx_pkg::*;
(
   input  logic                in_valid,
   input  emesh_txn_t          in_txn,                   // Already translated
   output logic                in_ready,
   input  logic [NUM_CHAN-1:0] q_ready,                  // Per queue not full
   input  logic [NUM_CHAN-1:0] q_progfull,               // Per queue nearly full
   output logic [NUM_CHAN-1:0] q_valid,                  // One-hot push
   output emesh_txn_t          q_txn,                    // Shared by all queues
   output logic                rx_wr_wait,
   output logic                rx_rd_wait
);

   chan_e         chan_sel;                              // Target queue
   logic [MMU_ENT_W-1:0] tag;                            // Top address bits

   assign tag = in_txn.dstaddr[AW-1 -: MMU_ENT_W];

   always_comb
   begin
      if (!in_txn.write)
         chan_sel = CHAN_RQ;                             // Read request
      else if (tag == RR_TAG)
         chan_sel = CHAN_RR;                             // Response to an earlier read
      else
         chan_sel = CHAN_WR;                             // Plain host write
   end

   always_comb
   begin
      for (int i = 0; i < NUM_CHAN; i++)
         q_valid[i] = in_valid && (chan_sel == chan_e'(i));
   end

   assign q_txn    = in_txn;
   assign in_ready = q_ready[chan_sel];                  // Stall on the chosen queue only

   // Waits back to the sender
   assign rx_wr_wait = q_progfull[CHAN_WR];
   // Responses and requests both count as read traffic
   assign rx_rd_wait = q_progfull[CHAN_RQ] | q_progfull[CHAN_RR];

endmodule

//--- logic/erx_fifo.sv
`timescale 1ns/1ps

module erx_fifo
   import erx_pkg::*;
(
   input  logic       rx_lclk_div4,
   input  logic       arst_n,
   input  logic       in_valid,
   input  emesh_txn_t in_txn,
   output logic       in_ready,                          // Low when full
   output logic       progfull,                          // Nearly full
   output logic       out_valid,
   input  logic       out_ready,
   output emesh_txn_t out_txn
);

   emesh_txn_t            mem [FIFO_DEPTH];              // Circular buffer
   logic [FIFO_AW-1:0]    wr_ptr;
   logic [FIFO_AW-1:0]    rd_ptr;
   logic [FIFO_CNT_W-1:0] count;                         // Occupancy
   logic                  push;
   logic                  pop;

   assign in_ready  = (count != FIFO_CNT_W'(FIFO_DEPTH));
   assign out_valid = (count != '0);
   assign progfull  = (count >= FIFO_CNT_W'(FIFO_PROGFULL));
   assign out_txn   = mem[rd_ptr];                       // Head of queue

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   always_ff @(posedge rx_lclk_div4 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;                     // Wraps at depth
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;                       // Both at once, no change
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (push)
         mem[wr_ptr] <= in_txn;
   end

endmodule

//--- logic/erx.sv
`timescale 1ns/1ps

module erx
   import erx_pkg::*;
(
   input  logic                 rx_lclk_div4,
   input  logic                 arst_n,
   input  rx_beat_t             beat,                    // Deserialized frame and data
   input  logic                 mmu_en,
   input  mi_req_t              mi,                      // Table config
   output logic [MMU_ENT_W-1:0] mi_dout,
   output logic                 rx_wr_wait,              // Write pushback to sender
   output logic                 rx_rd_wait,              // Read pushback to sender
   input  logic [NUM_CHAN-1:0]  chan_ready,              // Host side ready
   output logic [NUM_CHAN-1:0]  chan_valid,
   output emesh_txn_t           chan_txn [NUM_CHAN]      // Indexed by chan_e
);

   logic                proto_valid;                     // Decoder to MMU
   emesh_txn_t          proto_txn;
   logic                mmu_in_ready;
   logic                mmu_valid;                       // MMU to distributor
   emesh_txn_t          mmu_txn;
   logic                disty_ready;
   logic [NUM_CHAN-1:0] q_valid;                         // Distributor to queues
   emesh_txn_t          q_txn;
   logic [NUM_CHAN-1:0] q_ready;
   logic [NUM_CHAN-1:0] q_progfull;

   erx_protocol u_protocol (
      .rx_lclk_div4 (rx_lclk_div4),
      .arst_n       (arst_n),
      .beat         (beat),
      .out_ready    (mmu_in_ready),
      .out_valid    (proto_valid),
      .out_txn      (proto_txn)
   );

   emmu u_emmu (
      .rx_lclk_div4 (rx_lclk_div4),
      .arst_n       (arst_n),
      .mmu_en       (mmu_en),
      .mi           (mi),
      .mi_dout      (mi_dout),
      .in_valid     (proto_valid),
      .in_txn       (proto_txn),
      .in_ready     (mmu_in_ready),
      .out_ready    (disty_ready),
      .out_valid    (mmu_valid),
      .out_txn      (mmu_txn)
   );

   erx_disty u_disty (
      .in_valid     (mmu_valid),
      .in_txn       (mmu_txn),
      .in_ready     (disty_ready),
      .q_ready      (q_ready),
      .q_progfull   (q_progfull),
      .q_valid      (q_valid),
      .q_txn        (q_txn),
      .rx_wr_wait   (rx_wr_wait),
      .rx_rd_wait   (rx_rd_wait)
   );

   // One queue per channel, write, request, response
   for (genvar i = 0; i < NUM_CHAN; i++)
   begin : g_fifo
      erx_fifo u_fifo (
         .rx_lclk_div4 (rx_lclk_div4),
         .arst_n       (arst_n),
         .in_valid     (q_valid[i]),
         .in_txn       (q_txn),
         .in_ready     (q_ready[i]),
         .progfull     (q_progfull[i]),
         .out_valid    (chan_valid[i]),
         .out_ready    (chan_ready[i]),
         .out_txn      (chan_txn[i])
      );
   end

endmodule

//--- dv/erx_clk_gen.sv
`timescale 1ns/1ps

module erx_clk_gen
#(
   parameter int RST_CYC = 16                            // Clocks held in reset
)
(
   output logic rx_lclk_div4,
   output logic arst_n
);

   initial
   begin
      rx_lclk_div4 = 1'b0;
      forever #20 rx_lclk_div4 = ~rx_lclk_div4;          // 40 ns period
   end

   initial
   begin
      arst_n = 1'b0;
      repeat (RST_CYC) @(posedge rx_lclk_div4);
      #2;
      arst_n = 1'b1;                                     // Release off the edge
   end

endmodule

//--- dv/erx_sva.sv
`timescale 1ns/1ps

module erx_sva
   import erx_pkg::*;
(
   input logic       rx_lclk_div4,
   input logic       arst_n,
   input logic       in_valid,
   input logic       in_ready,
   input logic       full,                               // Stage or queue cannot take more
   input logic       out_valid,
   input logic       out_ready,
   input emesh_txn_t out_txn
);

   // Offered transaction held until taken
   a_out_hold : assert property (@(posedge rx_lclk_div4) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_txn))
      else $error("Output valid or payload changed before ready");

   // Accepted input never lands on a held entry
   a_no_overrun : assert property (@(posedge rx_lclk_div4) disable iff (!arst_n)
      in_valid && in_ready |-> !full)
      else $error("Transaction accepted while storage was full");

   // Stalled request stays up
   a_in_hold : assert property (@(posedge rx_lclk_div4) disable iff (!arst_n)
      in_valid && !in_ready |=> in_valid)
      else $error("Input valid dropped before ready");

endmodule

// Decoder has no input handshake, a body beat must not meet a held output
bind erx_protocol erx_sva u_sva (
   .rx_lclk_div4 (rx_lclk_div4),
   .arst_n       (arst_n),
   .in_valid     (beat_ok && (state == ST_BODY)),
   .in_ready     (1'b1),
   .full         (out_valid && !out_ready),
   .out_valid    (out_valid),
   .out_ready    (out_ready),
   .out_txn      (out_txn)
);

bind emmu erx_sva u_sva (
   .rx_lclk_div4 (rx_lclk_div4),
   .arst_n       (arst_n),
   .in_valid     (in_valid),
   .in_ready     (in_ready),
   .full         (out_valid && !out_ready),          // Pending stage not draining
   .out_valid    (out_valid),
   .out_ready    (out_ready),
   .out_txn      (out_txn)
);

bind erx_fifo erx_sva u_sva (
   .rx_lclk_div4 (rx_lclk_div4),
   .arst_n       (arst_n),
   .in_valid     (in_valid),
   .in_ready     (in_ready),
   .full         ((wr_ptr == rd_ptr) && (count != '0)),  // Pointers meet on a used queue
   .out_valid    (out_valid),
   .out_ready    (out_ready),
   .out_txn      (out_txn)
);

//--- dv/erx_tb.sv
`timescale 1ns/1ps

module erx_tb
   import erx_pkg::*;
();

   localparam int          RST_CYC     = 16;             // Reset length in clocks
   localparam int          NUM_ROWS    = 32;             // Packets in the table
   localparam int          NUM_BP      = 20;             // Stalled packets in test 5
   localparam int          DRAIN_CYC   = 100;            // Drain limit per test
   localparam int          TIMEOUT_CYC = 40 * NUM_ROWS + RST_CYC;
   localparam logic [31:0] SEED        = 32'h10cd_a745;

   typedef struct packed {
      logic [2:0]          test;                         // Owning test
      logic                write;
      dmode_e              datamode;
      logic [3:0]          ctrlmode;
      logic [AW-1:0]       dstaddr;                      // Before translation
      logic                mmu_en;
      logic [NUM_CHAN-1:0] ready;                        // Host ready per channel
      chan_e               exp_chan;                     // Queue it must leave by
   } row_t;

   logic                 rx_lclk_div4;
   logic                 arst_n;
   rx_beat_t             beat;
   logic                 mmu_en;
   mi_req_t              mi;
   logic [MMU_ENT_W-1:0] mi_dout;
   logic                 rx_wr_wait;
   logic                 rx_rd_wait;
   logic [NUM_CHAN-1:0]  chan_ready;
   logic [NUM_CHAN-1:0]  chan_valid;
   emesh_txn_t           chan_txn [NUM_CHAN];

   row_t        rows [NUM_ROWS];                         // Stimulus table
   emesh_txn_t  exp_q [NUM_CHAN][$];                     // Expected, in arrival order
   logic [31:0] rng;
   logic        saw_wait;                                // Write wait seen while sending
   logic        saw_rd_wait;                             // Read wait seen while sending
   int          errors    = 0;
   int          checks    = 0;
   int          tests     = 0;
   int          cycle_cnt = 0;

   erx_clk_gen #(
      .RST_CYC      (RST_CYC)
   ) u_clk (
      .rx_lclk_div4 (rx_lclk_div4),
      .arst_n       (arst_n)
   );

   erx dut (
      .rx_lclk_div4 (rx_lclk_div4),
      .arst_n       (arst_n),
      .beat         (beat),
      .mmu_en       (mmu_en),
      .mi           (mi),
      .mi_dout      (mi_dout),
      .rx_wr_wait   (rx_wr_wait),
      .rx_rd_wait   (rx_rd_wait),
      .chan_ready   (chan_ready),
      .chan_valid   (chan_valid),
      .chan_txn     (chan_txn)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Index 0 lands on the response prefix, others spread over all bits
   function automatic logic [MMU_ENT_W-1:0] ent_pattern(input logic [MMU_IDX_W-1:0] idx);
      return RR_TAG ^ {idx, idx, idx};
   endfunction

   task automatic load_table();
      rows[0]  = '{3'd2, 1'b1, DMODE_WORD,   4'h0, 32'h0000_1000, 1'b0, 3'b111, CHAN_WR};
      rows[1]  = '{3'd2, 1'b1, DMODE_BYTE,   4'h3, 32'h1234_5678, 1'b0, 3'b111, CHAN_WR};
      rows[2]  = '{3'd2, 1'b1, DMODE_HALF,   4'hA, 32'h7FFF_FFFE, 1'b0, 3'b111, CHAN_WR};
      rows[3]  = '{3'd2, 1'b1, DMODE_DOUBLE, 4'hF, 32'hFFF0_0008, 1'b0, 3'b111, CHAN_WR};
      rows[4]  = '{3'd3, 1'b0, DMODE_WORD,   4'h1, 32'h4000_1000, 1'b0, 3'b111, CHAN_RQ};
      rows[5]  = '{3'd3, 1'b0, DMODE_WORD,   4'h2, 32'h8100_0040, 1'b0, 3'b111, CHAN_RQ};
      rows[6]  = '{3'd3, 1'b1, DMODE_WORD,   4'h4, 32'h8100_0080, 1'b0, 3'b111, CHAN_RR};
      rows[7]  = '{3'd3, 1'b1, DMODE_HALF,   4'h5, 32'h8110_0000, 1'b0, 3'b111, CHAN_WR};
      rows[8]  = '{3'd4, 1'b1, DMODE_WORD,   4'h6, 32'h0ABC_DEF0, 1'b1, 3'b111, CHAN_RR};
      rows[9]  = '{3'd4, 1'b1, DMODE_WORD,   4'h7, 32'h5123_4567, 1'b1, 3'b111, CHAN_WR};
      rows[10] = '{3'd4, 1'b0, DMODE_WORD,   4'h8, 32'hF000_0010, 1'b1, 3'b111, CHAN_RQ};
      rows[11] = '{3'd4, 1'b1, DMODE_BYTE,   4'h9, 32'h8100_0000, 1'b1, 3'b111, CHAN_WR};
      for (int k = 0; k < NUM_BP; k++)                   // Write queue held off
         rows[12 + k] = '{3'd5, 1'b1, DMODE_WORD, 4'(k),
                          AW'(32'h2000_0000 + 4 * k), 1'b0, 3'b110, CHAN_WR};
   endtask

   task automatic check_txn(input chan_e ch, input emesh_txn_t got, input emesh_txn_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t: %s got %h, expected %h", $time, ch.name(), got, exp);
      end
   endtask

   task automatic check_ent(input logic [MMU_IDX_W-1:0] idx,
                            input logic [MMU_ENT_W-1:0] got,
                            input logic [MMU_ENT_W-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t: table entry %0d reads %h, expected %h", $time, idx, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic table_test();
      for (int i = 0; i < MMU_ENTRIES; i++)
      begin
         mi = '{1'b1, 1'b1, 4'(i), ent_pattern(4'(i))};  // Config write
         @(posedge rx_lclk_div4);
         #2;
      end
      for (int i = 0; i < MMU_ENTRIES; i++)
      begin
         mi = '{1'b1, 1'b0, 4'(i), 12'h000};             // Readback only
         @(posedge rx_lclk_div4);                         // Settled for a full cycle
         check_ent(4'(i), mi_dout, ent_pattern(4'(i)));
         #2;
      end
      mi = '0;
   endtask

   task automatic send_packet(input row_t r);
      emesh_txn_t t;
      while (rx_wr_wait || rx_rd_wait)
      begin
         saw_wait    = saw_wait | rx_wr_wait;
         saw_rd_wait = saw_rd_wait | rx_rd_wait;
         chan_ready  = '1;                               // Host drains while sender holds
         @(posedge rx_lclk_div4);
         #2;
      end
      t.write    = r.write;
      t.datamode = r.datamode;
      t.ctrlmode = r.ctrlmode;
      t.dstaddr  = r.dstaddr;
      rng        = xorshift(rng);
      t.data     = rng;
      rng        = xorshift(rng);
      t.srcaddr  = rng;
      mmu_en     = r.mmu_en;
      chan_ready = r.ready;
      beat.frame = '1;
      beat.data  = {t.write, t.datamode, t.ctrlmode, 25'd0, t.dstaddr};  // Head
      @(posedge rx_lclk_div4);
      #2;
      beat.data  = {t.data, t.srcaddr};                  // Body
      @(posedge rx_lclk_div4);
      #2;
      beat       = '0;                                   // Idle until next head
      if (r.mmu_en)                                      // Top bits swapped by entry
         t.dstaddr = {ent_pattern(r.dstaddr[AW-1 -: MMU_IDX_W]),
                      r.dstaddr[AW-MMU_ENT_W-1:0]};
      exp_q[r.exp_chan].push_back(t);
   endtask

   task automatic send_rows(input logic [2:0] id);
      for (int i = 0; i < NUM_ROWS; i++)
         if (rows[i].test == id)
            send_packet(rows[i]);
   endtask

   task automatic wait_drain();
      int waited;
      waited     = 0;
      chan_ready = '1;
      while ((exp_q[0].size() + exp_q[1].size() + exp_q[2].size()) != 0 &&
             waited < DRAIN_CYC)
      begin
         @(posedge rx_lclk_div4);
         #2;
         waited++;
      end
      for (int i = 0; i < NUM_CHAN; i++)
         if (exp_q[i].size() != 0)
         begin
            errors += exp_q[i].size();
            $display("%0d transactions never arrived on channel %0d", exp_q[i].size(), i);
            exp_q[i].delete();
         end
      repeat (4)                                         // Strays show up here
      begin
         @(posedge rx_lclk_div4);
         #2;
      end
   endtask

   task automatic report_test(input int id, input string name, input int mark);
      tests++;
      $display("Test %0d %s: %s, %0d errors", id, name,
               (errors == mark) ? "ok" : "failed", errors - mark);
   endtask

   // Transfer happens on the next rising edge, inputs are steady here
   always @(negedge rx_lclk_div4)
   begin
      if (arst_n)
         for (int i = 0; i < NUM_CHAN; i++)
            if (chan_valid[i] && chan_ready[i])
            begin
               if (exp_q[i].size() == 0)
               begin
                  errors++;
                  $display("Unexpected transaction on channel %0d at %0t", i, $time);
               end
               else
                  check_txn(chan_e'(2'(i)), chan_txn[i], exp_q[i].pop_front());
            end
   end

   always @(posedge rx_lclk_div4)
   begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYC)
      begin
         $display("Timeout: the run hung after %0d cycles", cycle_cnt);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   initial
   begin
      int mark;
      beat        = '0;
      mmu_en      = 1'b0;
      mi          = '0;
      chan_ready  = '1;
      rng         = SEED;
      saw_wait    = 1'b0;
      saw_rd_wait = 1'b0;
      load_table();
      wait (arst_n === 1'b1);
      @(posedge rx_lclk_div4);
      #2;

      mark = errors;
      table_test();
      report_test(1, "table readback", mark);

      mark = errors;
      send_rows(3'd2);
      wait_drain();
      report_test(2, "writes untranslated", mark);

      mark = errors;
      send_rows(3'd3);
      wait_drain();
      report_test(3, "read and response routing", mark);

      mark = errors;
      send_rows(3'd4);
      wait_drain();
      report_test(4, "translated routing", mark);

      mark        = errors;
      saw_wait    = 1'b0;
      saw_rd_wait = 1'b0;
      send_rows(3'd5);
      check_flag("rx_wr_wait during write stall", saw_wait, 1'b1);
      check_flag("rx_rd_wait during write stall", saw_rd_wait, 1'b0);
      wait_drain();
      check_flag("rx_wr_wait after drain", rx_wr_wait, 1'b0);
      check_flag("rx_rd_wait after drain", rx_rd_wait, 1'b0);
      report_test(5, "write back-pressure", mark);

      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

//--- erx.f
logic/erx_pkg.sv
logic/erx_protocol.sv
logic/emmu.sv
logic/erx_disty.sv
logic/erx_fifo.sv
logic/erx.sv
dv/erx_clk_gen.sv
dv/erx_sva.sv
dv/erx_tb.sv

//--- Makefile
# Verilator build and run of the receive path testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module erx_tb -f erx.f
	@out=$$(./obj_dir/Verx_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
